//--- source/tlk2711_tx_macros.svh
// tlk2711 tx widths and depths shared by packages and modules
`ifndef TLK2711_TX_MACROS_SVH
`define TLK2711_TX_MACROS_SVH

// byte address width of the memory side
`define TX_ADDR_WIDTH 32

// byte length fields
`define TX_DLEN_WIDTH 16

// memory word and stream word, 8 bytes
`define TX_WORD_WIDTH 64

// command fifo entries
`define TX_FIFO_DEPTH 4

// flat command word, address plus length
`define TX_CMD_WIDTH (`TX_ADDR_WIDTH + `TX_DLEN_WIDTH)

`endif

//--- source/tlk2711_tx_pkg.sv
// tlk2711 tx package: transfer configuration and tx mode encoding
`include "tlk2711_tx_macros.svh"

package tlk2711_tx_pkg;

    // tx mode field of the control register
    // only normal and specific modes move memory data
    typedef enum logic [2:0] {
        NORM_MODE     = 3'd0,
        KCODE_MODE    = 3'd1,
        TEST_MODE     = 3'd2, // chip to chip test pattern
        SPECIFIC_MODE = 3'd3
    } tx_mode_e;

    // transfer setup, sampled on a qualified start
    // lengths are in bytes, not yet aligned
    typedef struct packed {
        // byte address of the first body frame
        logic [`TX_ADDR_WIDTH-1:0] base_addr;
        logic [`TX_DLEN_WIDTH-1:0] body_len;
        logic [`TX_DLEN_WIDTH-1:0] tail_len;
        // body frames sent before the single tail
        logic [`TX_DLEN_WIDTH-1:0] body_num;
    } tx_cfg_t;

endpackage

//--- source/tlk2711_dma_pkg.sv
// tlk2711 dma package: read command word and outgoing stream word
`include "tlk2711_tx_macros.svh"

package tlk2711_dma_pkg;

    // one dma read command
    // start address in the high bits, byte count low
    typedef struct packed {
        logic [`TX_ADDR_WIDTH-1:0] saddr;
        logic [`TX_DLEN_WIDTH-1:0] byte_len;
    } dma_cmd_t;

    // same command word, field view or flat storage view
    // fifo keeps raw, generator and reader use the fields
    typedef union packed {
        dma_cmd_t                 cmd;
        logic [`TX_CMD_WIDTH-1:0] raw;
    } dma_cmd_word_u;

    // stream word toward the serializer
    typedef struct packed {
        logic [`TX_WORD_WIDTH-1:0] data;
        // final word of a command
        logic                      last;
    } tx_word_t;

endpackage

//--- source/tlk2711_tx_cmd.sv
// tlk2711 tx command generator: splits a frame transfer into aligned dma read commands
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tlk2711_tx_cmd (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_soft_rst,
    // start and transfer setup
    input  logic                           i_tx_start,
    input  tlk2711_tx_pkg::tx_mode_e       i_tx_mode,
    input  tlk2711_tx_pkg::tx_cfg_t        i_tx_cfg,
    // four-phase link toward the command fifo
    input  logic                           i_cmd_ack,
    output logic                           o_cmd_req,
    output tlk2711_dma_pkg::dma_cmd_word_u o_cmd,
    // completion from the reader
    input  logic                           i_cmd_done,
    output logic                           o_tx_busy,
    output logic                           o_tx_done
);

    import tlk2711_tx_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_ACK_HI,
        ST_ACK_LO,
        ST_DRAIN
    } cmd_state_e;

    cmd_state_e                state;
    logic                      mode_ok;
    logic                      start_d;
    logic                      start_edge;
    logic                      tx_start;
    logic                      is_tail;
    logic [`TX_ADDR_WIDTH-1:0] rd_addr;
    logic [`TX_DLEN_WIDTH-1:0] body_al;
    logic [`TX_DLEN_WIDTH-1:0] tail_al;
    logic [`TX_DLEN_WIDTH-1:0] body_num;
    logic [`TX_DLEN_WIDTH-1:0] issue_cnt;
    logic [`TX_DLEN_WIDTH-1:0] done_cnt;

    // round a byte count up to whole 8-byte words
    function automatic logic [`TX_DLEN_WIDTH-1:0] align8(
        input logic [`TX_DLEN_WIDTH-1:0] len
    );
        logic [`TX_DLEN_WIDTH-1:0] up;
        up = len + `TX_DLEN_WIDTH'(7);
        return {up[`TX_DLEN_WIDTH-1:3], 3'b000};
    endfunction

    //////////////////////////////////////////////////
    // start qualification
    //////////////////////////////////////////////////

    // kcode and test traffic never reach the dma path
    assign mode_ok    = (i_tx_mode == NORM_MODE) || (i_tx_mode == SPECIFIC_MODE);
    assign start_edge = i_tx_start & mode_ok & ~start_d;

    // edge history survives soft reset, a held start must not retrigger
    always_ff @(posedge clk) begin
        if (rst) begin
            start_d <= 1'b0;
        end else begin
            start_d <= i_tx_start & mode_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_soft_rst) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= start_edge;
        end
    end

    //////////////////////////////////////////////////
    // transfer setup and address walk
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && tx_start) begin
            rd_addr  <= i_tx_cfg.base_addr;
            body_al  <= align8(i_tx_cfg.body_len);
            tail_al  <= align8(i_tx_cfg.tail_len);
            body_num <= i_tx_cfg.body_num;
        end else if (state == ST_ACK_HI && i_cmd_ack) begin
            // next frame starts one aligned body further on
            rd_addr <= rd_addr + `TX_ADDR_WIDTH'(body_al);
        end
    end

    // body_num bodies first, then the tail once
    assign is_tail = (issue_cnt == body_num);
    assign o_cmd.cmd = '{saddr: rd_addr, byte_len: is_tail ? tail_al : body_al};
    assign o_tx_busy = (state != ST_IDLE);

    //////////////////////////////////////////////////
    // command issue fsm and completion count
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || i_soft_rst) begin
            state     <= ST_IDLE;
            o_cmd_req <= 1'b0;
            o_tx_done <= 1'b0;
            issue_cnt <= '0;
            done_cnt  <= '0;
        end else begin
            o_tx_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (tx_start) begin
                        state     <= ST_ISSUE;
                        issue_cnt <= '0;
                        done_cnt  <= '0;
                    end
                end
                ST_ISSUE: begin
                    // address and length already stable here
                    o_cmd_req <= 1'b1;
                    state     <= ST_ACK_HI;
                end
                ST_ACK_HI: begin
                    if (i_cmd_ack) begin
                        o_cmd_req <= 1'b0;
                        issue_cnt <= issue_cnt + 1'b1;
                        state     <= is_tail ? ST_DRAIN : ST_ACK_LO;
                    end
                end
                ST_ACK_LO: begin
                    // close the handshake before the next req
                    if (!i_cmd_ack) begin
                        state <= ST_ISSUE;
                    end
                end
                default: begin
                    // drain, wait for the reader to finish
                end
            endcase

            // completions may overlap issuing, counted in any busy state
            if (state != ST_IDLE && i_cmd_done) begin
                if (done_cnt == body_num) begin
                    o_tx_done <= 1'b1;
                    state     <= ST_IDLE;
                end else begin
                    done_cnt <= done_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- source/tlk2711_cmd_fifo.sv
// tlk2711 command fifo: buffers dma commands between two four-phase links
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tlk2711_cmd_fifo (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_soft_rst,
    // write side, from the generator
    input  logic                           i_wr_req,
    input  tlk2711_dma_pkg::dma_cmd_word_u i_wr_data,
    output logic                           o_wr_ack,
    // read side, toward the reader
    input  logic                           i_rd_ack,
    output logic                           o_rd_req,
    output tlk2711_dma_pkg::dma_cmd_word_u o_rd_data
);

    localparam int DEPTH = `TX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`TX_CMD_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [PTR_W:0]           count;
    logic                     full;
    logic                     empty;
    logic                     push;
    logic                     pop;

    // wrap for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == DEPTH[PTR_W:0]);
    assign empty = (count == '0);

    // store on the ack rise, only with room
    assign push = i_wr_req & ~o_wr_ack & ~full;
    // pop on the reader's ack rise
    assign pop  = o_rd_req & i_rd_ack;

    // storage, raw view only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_data.raw;
        end
    end

    assign o_rd_data.raw = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || i_soft_rst) begin
            o_wr_ack <= 1'b0;
            o_rd_req <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            // write handshake
            if (push) begin
                o_wr_ack <= 1'b1;
                wr_ptr   <= next_ptr(wr_ptr);
            end else if (o_wr_ack && !i_wr_req) begin
                o_wr_ack <= 1'b0;
            end

            // read handshake, new req only once the old ack is gone
            if (pop) begin
                o_rd_req <= 1'b0;
                rd_ptr   <= next_ptr(rd_ptr);
            end else if (!o_rd_req && !i_rd_ack && !empty) begin
                o_rd_req <= 1'b1;
            end

            // push and pop may land together
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

endmodule

//--- source/tlk2711_dma_reader.sv
// tlk2711 dma reader: fetches command words from memory and streams them out
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tlk2711_dma_reader (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_soft_rst,
    // four-phase command link from the fifo
    input  logic                           i_cmd_req,
    input  tlk2711_dma_pkg::dma_cmd_word_u i_cmd,
    output logic                           o_cmd_ack,
    // combinational memory read port
    output logic [`TX_ADDR_WIDTH-1:0]      o_mem_addr,
    input  logic [`TX_WORD_WIDTH-1:0]      i_mem_data,
    // word stream
    output logic                           o_tx_valid,
    output tlk2711_dma_pkg::tx_word_t      o_tx_word,
    input  logic                           i_tx_ready,
    // end of each command
    output logic                           o_cmd_done
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_LOAD,
        RD_RUN
    } rd_state_e;

    rd_state_e                 state;
    logic [`TX_ADDR_WIDTH-4:0] word_addr;
    logic [`TX_DLEN_WIDTH-4:0] words_left;
    logic                      take;
    logic                      accept;
    logic                      last_word;
    logic                      empty_done;

    // take a command only while idle and after the last ack closed
    assign take      = (state == RD_IDLE) & i_cmd_req & ~o_cmd_ack;
    assign accept    = o_tx_valid & i_tx_ready;
    assign last_word = (words_left == 1);

    assign o_mem_addr = {word_addr, 3'b000};
    assign o_tx_valid = (state == RD_RUN);
    // memory data passes straight through, held by a held address
    assign o_tx_word  = '{data: i_mem_data, last: last_word};

    // zero-length command still completes, without any word
    assign o_cmd_done = (accept & last_word) | empty_done;

    //////////////////////////////////////////////////
    // word address and remaining count
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (take) begin
            word_addr  <= i_cmd.cmd.saddr[`TX_ADDR_WIDTH-1:3];
            words_left <= i_cmd.cmd.byte_len[`TX_DLEN_WIDTH-1:3];
        end else if (accept) begin
            // step only on a transferred word
            word_addr  <= word_addr + 1'b1;
            words_left <= words_left - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // command handshake and stream control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || i_soft_rst) begin
            state      <= RD_IDLE;
            o_cmd_ack  <= 1'b0;
            empty_done <= 1'b0;
        end else begin
            empty_done <= 1'b0;

            // ack falls once the fifo drops req
            if (take) begin
                o_cmd_ack <= 1'b1;
            end else if (o_cmd_ack && !i_cmd_req) begin
                o_cmd_ack <= 1'b0;
            end

            case (state)
                RD_IDLE: begin
                    if (take) begin
                        state <= RD_LOAD;
                    end
                end
                RD_LOAD: begin
                    // count loaded, first word shows next cycle
                    if (words_left == '0) begin
                        empty_done <= 1'b1;
                        state      <= RD_IDLE;
                    end else begin
                        state <= RD_RUN;
                    end
                end
                RD_RUN: begin
                    if (accept && last_word) begin
                        state <= RD_IDLE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/tlk2711_tx_top.sv
// tlk2711 tx top: command generator, command fifo and dma reader
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tlk2711_tx_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_soft_rst,
    // transfer request
    input  logic                      i_tx_start,
    input  tlk2711_tx_pkg::tx_mode_e  i_tx_mode,
    input  tlk2711_tx_pkg::tx_cfg_t   i_tx_cfg,
    // memory read port
    output logic [`TX_ADDR_WIDTH-1:0] o_mem_addr,
    input  logic [`TX_WORD_WIDTH-1:0] i_mem_data,
    // word stream toward the serializer
    output logic                      o_tx_valid,
    output tlk2711_dma_pkg::tx_word_t o_tx_word,
    input  logic                      i_tx_ready,
    // transfer status
    output logic                      o_tx_busy,
    output logic                      o_tx_done
);

    import tlk2711_dma_pkg::*;

    // generator to fifo
    logic          gen_req;
    logic          gen_ack;
    dma_cmd_word_u gen_cmd;
    // fifo to reader
    logic          rd_req;
    logic          rd_ack;
    dma_cmd_word_u rd_cmd;
    // reader back to generator
    logic          cmd_done;

    tlk2711_tx_cmd u_tx_cmd (
        .clk        (clk),
        .rst        (rst),
        .i_soft_rst (i_soft_rst),
        .i_tx_start (i_tx_start),
        .i_tx_mode  (i_tx_mode),
        .i_tx_cfg   (i_tx_cfg),
        .i_cmd_ack  (gen_ack),
        .o_cmd_req  (gen_req),
        .o_cmd      (gen_cmd),
        .i_cmd_done (cmd_done),
        .o_tx_busy  (o_tx_busy),
        .o_tx_done  (o_tx_done)
    );

    tlk2711_cmd_fifo u_cmd_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_soft_rst (i_soft_rst),
        .i_wr_req   (gen_req),
        .i_wr_data  (gen_cmd),
        .o_wr_ack   (gen_ack),
        .i_rd_ack   (rd_ack),
        .o_rd_req   (rd_req),
        .o_rd_data  (rd_cmd)
    );

    tlk2711_dma_reader u_dma_reader (
        .clk        (clk),
        .rst        (rst),
        .i_soft_rst (i_soft_rst),
        .i_cmd_req  (rd_req),
        .i_cmd      (rd_cmd),
        .o_cmd_ack  (rd_ack),
        .o_mem_addr (o_mem_addr),
        .i_mem_data (i_mem_data),
        .o_tx_valid (o_tx_valid),
        .o_tx_word  (o_tx_word),
        .i_tx_ready (i_tx_ready),
        .o_cmd_done (cmd_done)
    );

endmodule

//--- verif/tb_tlk2711_tx_top.sv
// tlk2711 tx testbench with memory model, stimulus and assertion checks of the dma word stream
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tb_tlk2711_tx_top;

    import tlk2711_tx_pkg::*;
    import tlk2711_dma_pkg::*;

    localparam int CYCLE_LIMIT = 4000;

    // 870 bytes align to 872 for 109 words per body, 13 bytes to 16 for 2 tail words
    localparam tx_cfg_t CFG_A  = '{base_addr: 32'h0001_0000, body_len: 16'd870,
                                   tail_len: 16'd13, body_num: 16'd3};
    localparam tx_cfg_t CFG_B  = '{base_addr: 32'h0004_1000, body_len: 16'd870,
                                   tail_len: 16'd13, body_num: 16'd3};
    localparam tx_cfg_t CFG_C1 = '{base_addr: 32'h0008_0000, body_len: 16'd870,
                                   tail_len: 16'd13, body_num: 16'd3};
    localparam tx_cfg_t CFG_C2 = '{base_addr: 32'h000c_0000, body_len: 16'd100,
                                   tail_len: 16'd41, body_num: 16'd2};

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      i_soft_rst;
    logic                      i_tx_start;
    tx_mode_e                  i_tx_mode;
    tx_cfg_t                   i_tx_cfg;
    logic [`TX_ADDR_WIDTH-1:0] o_mem_addr;
    logic [`TX_WORD_WIDTH-1:0] i_mem_data;
    logic                      o_tx_valid;
    tx_word_t                  o_tx_word;
    logic                      i_tx_ready = 1'b0;
    logic                      o_tx_busy;
    logic                      o_tx_done;

    // expected stream of one entry per word filled before each start
    logic [`TX_ADDR_WIDTH-1:0] exp_addr_mem [0:2047];
    logic                      exp_last_mem [0:2047];
    logic [10:0]               exp_wr;
    logic [10:0]               exp_rd;
    logic [10:0]               done_mark;
    logic [`TX_ADDR_WIDTH-1:0] exp_addr;
    logic [`TX_WORD_WIDTH-1:0] exp_data;
    logic                      exp_last;

    // one cycle of history
    tx_word_t                  prev_word;
    logic                      prev_stall;
    logic                      prev_busy;
    logic                      prev_soft;

    logic                      quiet;
    logic                      rand_ready;
    logic [31:0]               lcg_state = 32'hf4aa;
    int                        cycle_cnt = 0;
    int                        assert_errs = 0;
    int                        check_errs;

    // memory contents are the address twice with a fixed xor
    function automatic logic [`TX_WORD_WIDTH-1:0] mem_word(
        input logic [`TX_ADDR_WIDTH-1:0] addr
    );
        return {addr, addr} ^ 64'h5a5a_0000_5a5a_0000;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    always #20 clk = ~clk;

    tlk2711_tx_top u_tlk2711_tx_top (
        .clk        (clk),
        .rst        (rst),
        .i_soft_rst (i_soft_rst),
        .i_tx_start (i_tx_start),
        .i_tx_mode  (i_tx_mode),
        .i_tx_cfg   (i_tx_cfg),
        .o_mem_addr (o_mem_addr),
        .i_mem_data (i_mem_data),
        .o_tx_valid (o_tx_valid),
        .o_tx_word  (o_tx_word),
        .i_tx_ready (i_tx_ready),
        .o_tx_busy  (o_tx_busy),
        .o_tx_done  (o_tx_done)
    );

    // combinational read port
    assign i_mem_data = mem_word(o_mem_addr);

    assign exp_addr = exp_addr_mem[exp_rd];
    assign exp_last = exp_last_mem[exp_rd];
    assign exp_data = mem_word(exp_addr);

    // ready runs at about half duty once randomized
    always @(posedge clk) begin
        if (rand_ready) begin
            lcg_state  <= lcg_next(lcg_state);
            i_tx_ready <= lcg_state[30];
        end else begin
            i_tx_ready <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // model pointer and history
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            exp_rd     <= '0;
            done_mark  <= '0;
            prev_stall <= 1'b0;
            prev_busy  <= 1'b0;
            prev_soft  <= 1'b0;
        end else begin
            // skip what is left of an aborted transfer
            if (i_soft_rst) begin
                exp_rd <= exp_wr;
            end else if (o_tx_valid && i_tx_ready) begin
                exp_rd <= exp_rd + 11'd1;
            end
            if (o_tx_done) begin
                done_mark <= exp_rd;
            end
            prev_stall <= o_tx_valid && !i_tx_ready && !i_soft_rst;
            prev_busy  <= o_tx_busy;
            prev_soft  <= i_soft_rst;
        end
        prev_word <= o_tx_word;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run stopped at the limit of %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stream and status checks
    //////////////////////////////////////////////////

    extra_word_check: assert property (@(posedge clk) disable iff (rst)
        o_tx_valid |-> (exp_rd < exp_wr)
    ) else begin
        assert_errs = assert_errs + 1;
        $display("stream word appeared with no word left in the model");
    end

    addr_check: assert property (@(posedge clk) disable iff (rst)
        o_tx_valid |-> (o_mem_addr == exp_addr)
    ) else begin
        assert_errs = assert_errs + 1;
        $display("[ERROR] o_mem_addr expected %08h actual %08h",
                 $sampled(exp_addr), $sampled(o_mem_addr));
    end

    data_check: assert property (@(posedge clk) disable iff (rst)
        o_tx_valid |-> (o_tx_word.data == exp_data)
    ) else begin
        assert_errs = assert_errs + 1;
        $display("[ERROR] o_tx_word.data expected %016h actual %016h",
                 $sampled(exp_data), $sampled(o_tx_word.data));
    end

    last_check: assert property (@(posedge clk) disable iff (rst)
        o_tx_valid |-> (o_tx_word.last == exp_last)
    ) else begin
        assert_errs = assert_errs + 1;
        $display("[ERROR] o_tx_word.last expected %h actual %h",
                 $sampled(exp_last), $sampled(o_tx_word.last));
    end

    // stalled word must stay put until taken
    hold_check: assert property (@(posedge clk) disable iff (rst)
        prev_stall |-> (o_tx_valid && (o_tx_word == prev_word))
    ) else begin
        assert_errs = assert_errs + 1;
        $display("[ERROR] o_tx_word under stall expected %017h actual %017h valid %h",
                 $sampled(prev_word), $sampled(o_tx_word), $sampled(o_tx_valid));
    end

    // busy high up to the done pulse and low with it
    done_check: assert property (@(posedge clk) disable iff (rst)
        o_tx_done |-> (prev_busy && !o_tx_busy && (exp_rd == exp_wr) && (exp_rd != done_mark))
    ) else begin
        assert_errs = assert_errs + 1;
        $display("o_tx_done came early, twice, or without o_tx_busy falling with it");
    end

    busy_fall_check: assert property (@(posedge clk) disable iff (rst)
        (prev_busy && !o_tx_busy && !prev_soft) |-> o_tx_done
    ) else begin
        assert_errs = assert_errs + 1;
        $display("o_tx_busy fell without o_tx_done");
    end

    // filtered modes, held start and the cycle after a soft reset
    idle_check: assert property (@(posedge clk) disable iff (rst)
        (quiet || prev_soft) |-> (!o_tx_valid && !o_tx_busy)
    ) else begin
        assert_errs = assert_errs + 1;
        $display("DUT was active where it had to stay idle");
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // expected (address, last) list of one transfer
    task automatic load_model(input tx_cfg_t cfg);
        logic [`TX_ADDR_WIDTH-1:0] addr;
        int body_al;
        int tail_al;
        int words;
        body_al = ((int'(cfg.body_len) + 7) / 8) * 8;
        tail_al = ((int'(cfg.tail_len) + 7) / 8) * 8;
        addr    = cfg.base_addr;
        for (int f = 0; f <= int'(cfg.body_num); f++) begin
            words = ((f < int'(cfg.body_num)) ? body_al : tail_al) / 8;
            for (int w = 0; w < words; w++) begin
                exp_addr_mem[exp_wr] = addr + `TX_ADDR_WIDTH'(8 * w);
                exp_last_mem[exp_wr] = (w == words - 1);
                exp_wr = exp_wr + 11'd1;
            end
            addr = addr + `TX_ADDR_WIDTH'(body_al);
        end
    endtask

    task automatic begin_transfer(input tx_cfg_t cfg, input logic hold);
        load_model(cfg);
        i_tx_mode  <= NORM_MODE;
        i_tx_cfg   <= cfg;
        i_tx_start <= 1'b1;
        @(posedge clk);
        if (!hold) begin
            i_tx_start <= 1'b0;
        end
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!o_tx_done && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!o_tx_done) begin
            check_errs++;
            $display("o_tx_done did not pulse within %0d cycles", limit);
        end
    endtask

    // start in a mode that carries no memory data
    task automatic try_idle_start(input tx_mode_e mode);
        i_tx_mode  <= mode;
        i_tx_start <= 1'b1;
        quiet      <= 1'b1;
        repeat (12) @(posedge clk);
        i_tx_start <= 1'b0;
        repeat (4) @(posedge clk);
        quiet      <= 1'b0;
    endtask

    initial begin
        logic [10:0] mark;
        check_errs = 0;
        exp_wr     = '0;
        rst        = 1'b1;
        i_soft_rst = 1'b0;
        i_tx_start = 1'b0;
        i_tx_mode  = NORM_MODE;
        i_tx_cfg   = '0;
        quiet      = 1'b0;
        rand_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        try_idle_start(KCODE_MODE);
        try_idle_start(TEST_MODE);

        // full ready with start kept high past the end
        begin_transfer(CFG_A, 1'b1);
        wait_done(1500);
        quiet <= 1'b1;
        repeat (20) @(posedge clk);
        i_tx_start <= 1'b0;
        quiet      <= 1'b0;
        repeat (4) @(posedge clk);

        // random back-pressure from here on
        rand_ready <= 1'b1;
        begin_transfer(CFG_B, 1'b0);
        wait_done(2000);
        repeat (8) @(posedge clk);

        // abort part way and start a fresh transfer elsewhere
        mark = exp_wr;
        begin_transfer(CFG_C1, 1'b0);
        while (exp_rd < mark + 11'd150) begin
            @(posedge clk);
        end
        i_soft_rst <= 1'b1;
        @(posedge clk);
        i_soft_rst <= 1'b0;
        repeat (4) @(posedge clk);
        begin_transfer(CFG_C2, 1'b0);
        wait_done(500);
        repeat (20) @(posedge clk);

        $display("errors: %0d from assertions, %0d from other checks", assert_errs, check_errs);
        if (assert_errs == 0 && check_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- tlk2711_tx_top.f
+incdir+source
source/tlk2711_tx_pkg.sv
source/tlk2711_dma_pkg.sv
source/tlk2711_tx_cmd.sv
source/tlk2711_cmd_fifo.sv
source/tlk2711_dma_reader.sv
source/tlk2711_tx_top.sv
verif/tb_tlk2711_tx_top.sv

//--- run.sh
#!/bin/sh
# build and run the tlk2711 tx testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tlk2711_tx_top.f \
    --top-module tb_tlk2711_tx_top \
    -o tb_tlk2711_tx_top

out=$(./obj_dir/tb_tlk2711_tx_top)
echo "$out"

# exit status follows the search result
echo "$out" | grep -q "SIMULATION PASSED"
